// File: twiddle_mul_top.f
+incdir+logic
logic/twiddle_pkg.sv
logic/operand_select.sv
logic/factor_delay_line.sv
logic/mod_mul_array.sv
logic/twiddle_mul_top.sv
test/twiddle_mul_tb.sv

// File: Bender.yml
package:
  name: twiddle_mul

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/twiddle_pkg.sv
      - logic/operand_select.sv
      - logic/factor_delay_line.sv
      - logic/mod_mul_array.sv
      - logic/twiddle_mul_top.sv

  - target: test
    include_dirs:
      - logic
    files:
      - test/twiddle_mul_tb.sv

// File: test/twiddle_mul_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "twiddle_macros.svh"

module twiddle_mul_tb
    import twiddle_pkg::*;
;

    localparam int lanes      = `TW_LANES;
    localparam int max_cycles = 2000;  // ~400 items plus gaps, about 900 cycles

    logic         clk;
    logic         rst_n;
    logic         in_valid;
    fft_stage_e   stage;
    operand_set_t operands;
    word_t        n;
    logic         out_valid;
    lane_vec_t    result;

    lane_vec_t exp_q [$];   // expected results, oldest first
    lane_vec_t exp_head;    // item due on result at the next rising edge
    logic      quiet;       // high from reset until the first item
    int        error_count;
    int        compared;
    int        cycle_count;

    twiddle_mul_top u_twiddle_mul_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .stage     (stage),
        .operands  (operands),
        .n         (n),
        .out_valid (out_valid),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // one lane by the stage rule, in 64-bit arithmetic
    function automatic word_t expected_lane(fft_stage_e st, word_t x0, word_t x1,
                                            word_t x2, word_t m);
        logic [63:0] acc;
        case (st)
            stage_full: begin
                acc = (64'(x0) * 64'(x1)) % 64'(m);
                acc = (acc * 64'(x2)) % 64'(m);
            end
            stage_pair: begin
                acc = (64'(x0) * 64'(x1)) % 64'(m);  // v2 ignored
            end
            default: begin
                acc = 64'(x0) % 64'(m);
            end
        endcase
        return acc[31:0];
    endfunction

    // edge values around n show up now and then
    function automatic word_t pick_factor(word_t m);
        int unsigned kind;
        kind = $urandom_range(0, 9);
        case (kind)
            0: return '0;
            1: return m;
            2: return m - 1;
            3: return '1;
            4: return m + 1;
            default: return $urandom();
        endcase
    endfunction

    task automatic send_item(input fft_stage_e st);
        operand_set_t ops;
        lane_vec_t    exp;
        for (int i = 0; i < lanes; i++) begin
            ops.v0[i] = pick_factor(n);
            ops.v1[i] = pick_factor(n);
            ops.v2[i] = pick_factor(n);
            exp[i]    = expected_lane(st, ops.v0[i], ops.v1[i], ops.v2[i], n);
        end
        @(posedge clk);
        in_valid <= 1'b1;
        stage    <= st;
        operands <= ops;
        exp_q.push_back(exp);
        quiet = 1'b0;
    endtask

    // idle cycles carry junk that must not leak into results
    task automatic send_gap(input int cycles);
        operand_set_t junk;
        for (int c = 0; c < cycles; c++) begin
            junk.v0 = {$urandom(), $urandom(), $urandom(), $urandom()};
            junk.v1 = {$urandom(), $urandom(), $urandom(), $urandom()};
            junk.v2 = {$urandom(), $urandom(), $urandom(), $urandom()};
            @(posedge clk);
            in_valid <= 1'b0;
            stage    <= fft_stage_e'($urandom_range(0, 3));
            operands <= junk;
        end
    endtask

    // load the next expected item half a cycle before it is checked
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                error_count++;
                $display("t=%0t out_valid high with no item pending", $time);
                exp_head <= 'x;
            end else begin
                exp_head <= exp_q.pop_front();
                compared++;
            end
        end
    end

    a_result_match: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> (result == exp_head)
    ) else begin
        error_count++;
        $display("FAIL t=%0t result expected %h got %h", $time,
                 $sampled(exp_head), $sampled(result));
    end

    a_out_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid |-> ##5 out_valid
    ) else begin
        error_count++;
        $display("t=%0t out_valid missing 5 cycles after an accepted item", $time);
    end

    a_gap_kept: assert property (
        @(posedge clk) disable iff (!rst_n)
        !in_valid |-> ##5 !out_valid
    ) else begin
        error_count++;
        $display("t=%0t out_valid high 5 cycles after an idle input cycle", $time);
    end

    a_reset_valid: assert property (
        @(negedge clk) (!rst_n || quiet) |-> (out_valid == 1'b0)
    ) else begin
        error_count++;
        $display("FAIL t=%0t out_valid expected 0 got %b", $time, $sampled(out_valid));
    end

    a_reset_result: assert property (
        @(negedge clk) (!rst_n || quiet) |-> (result == '0)
    ) else begin
        error_count++;
        $display("FAIL t=%0t result expected %h got %h", $time,
                 lane_vec_t'(0), $sampled(result));
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, %0d items still pending", max_cycles,
                 exp_q.size());
        $display("sim failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h27f1_a97d));
        error_count = 0;
        compared    = 0;
        quiet       = 1'b1;
        exp_head    = '0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        stage       = stage_full;
        operands    = '0;
        n           = $urandom() | 32'd1;  // odd, so never zero

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        send_gap(3);

        // all three factors, random gaps
        for (int k = 0; k < 150; k++) begin
            send_item(stage_full);
            send_gap($urandom_range(0, 3));
        end
        for (int k = 0; k < 60; k++) begin
            send_item(stage_pair);
            send_gap($urandom_range(0, 3));
        end
        for (int k = 0; k < 30; k++) begin
            send_item(stage_single_a);
            send_gap($urandom_range(0, 3));
        end
        for (int k = 0; k < 30; k++) begin
            send_item(stage_single_b);
            send_gap($urandom_range(0, 3));
        end

        // back to back, random stage
        for (int k = 0; k < 50; k++) begin
            send_item(fft_stage_e'($urandom_range(0, 3)));
        end
        send_gap(2);

        // stage steps on every item while earlier ones are in flight
        for (int k = 0; k < 80; k++) begin
            send_item(fft_stage_e'(k % 4));
            if ($urandom_range(0, 3) == 0) begin
                send_gap(1);
            end
        end

        send_gap(1);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        send_gap(6);  // let the gap checks on the tail complete

        $display("compared %0d results, %0d errors", compared, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/twiddle_mul_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "twiddle_macros.svh"

// (v0 * v1 mod n) * v2 mod n per lane
// latency: select 1 + rank one 2 + rank two 2 = 5 cycles
module twiddle_mul_top
    import twiddle_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         in_valid,
    input  fft_stage_e   stage,
    input  operand_set_t operands,
    input  word_t        n,
    output logic         out_valid,
    output lane_vec_t    result
);

    // selected operands
    logic         sel_valid;
    operand_set_t sel_ops;

    // first rank output, v0 * v1 mod n
    logic         p1_valid;
    lane_vec_t    p1;

    // v2 held back by one multiplier latency
    lane_vec_t    v2_late;

    // stage rule applied once, at entry
    operand_select u_select (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .stage     (stage),
        .operands  (operands),
        .sel_valid (sel_valid),
        .sel_ops   (sel_ops)
    );

    mod_mul_array #(
        .lanes (`TW_LANES)
    ) u_rank_one (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (sel_valid),
        .a         (sel_ops.v0),
        .b         (sel_ops.v1),
        .n         (n),
        .out_valid (p1_valid),
        .p         (p1)
    );

    // same depth as rank one
    factor_delay_line u_v2_delay (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (sel_valid),
        .factors      (sel_ops.v2),
        .late_factors (v2_late)
    );

    mod_mul_array #(
        .lanes (`TW_LANES)
    ) u_rank_two (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (p1_valid),
        .a         (p1),
        .b         (v2_late),  // aligned with p1
        .n         (n),
        .out_valid (out_valid),
        .p         (result)
    );

endmodule

`default_nettype wire

// File: logic/mod_mul_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "twiddle_macros.svh"

module mod_mul_array
    import twiddle_pkg::*;
#(
    parameter int lanes = `TW_LANES
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  word_t [lanes-1:0] a,
    input  word_t [lanes-1:0] b,
    input  word_t             n,       // shared modulus, held steady
    output logic              out_valid,
    output word_t [lanes-1:0] p
);

    logic  prod_valid;
    wide_t prod [lanes];   // full products, one per lane

    // valid walks two stages, so two items may be in flight
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            prod_valid <= in_valid;
            out_valid  <= prod_valid;
        end
    end

    // stage one: full width product
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < lanes; i++) begin
                prod[i] <= '0;
            end
        end else if (in_valid) begin
            for (int i = 0; i < lanes; i++) begin
                prod[i] <= wide_t'(a[i]) * wide_t'(b[i]);
            end
        end
    end

    // stage two: reduce mod n
    // only on a valid product, so an idle n of zero is never divided by
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            p <= '0;
        end else if (prod_valid) begin
            for (int i = 0; i < lanes; i++) begin
                p[i] <= word_t'(prod[i] % wide_t'(n));
            end
        end
    end

    // n is used one cycle after in_valid, so it must already be
    // nonzero when the item enters
    a_modulus_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid |-> (n != '0)
    );

    a_modulus_steady: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid |=> $stable(n)
    );

endmodule

`default_nettype wire

// File: logic/factor_delay_line.sv
`timescale 1ns/1ps
`default_nettype none

`include "twiddle_macros.svh"

module factor_delay_line
    import twiddle_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  lane_vec_t factors,
    output lane_vec_t late_factors
);

    localparam int depth = `TW_MUL_LAT;

    lane_vec_t taps [depth];

    // shifts every cycle, so position in the line matches the
    // position of the same item inside rank one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                taps[i] <= '0;
            end
        end else begin
            taps[0] <= factors;
            for (int i = 1; i < depth; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

    assign late_factors = taps[depth-1];  // lines up with p1

    // the valid beside this line steers rank two, an X there
    // would let a shifted factor pair with the wrong product
    a_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(in_valid)
    );

endmodule

`default_nettype wire

// File: logic/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module operand_select
    import twiddle_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         in_valid,
    input  fft_stage_e   stage,
    input  operand_set_t operands,
    output logic         sel_valid,
    output operand_set_t sel_ops
);

    operand_set_t ops_next;
    lane_vec_t    ones;

    assign ones = lane_fill(word_t'(1));

    // stage decides which factors are replaced by one
    always_comb begin
        ops_next = operands;
        unique case (stage)
            stage_full: begin
                ops_next = operands;
            end
            stage_pair: begin
                ops_next.v2 = ones;
            end
            stage_single_a,
            stage_single_b: begin
                ops_next.v1 = ones;
                ops_next.v2 = ones;
            end
        endcase
    end

    // the chosen v2 now rides with its own item
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_valid <= 1'b0;
            sel_ops   <= '0;
        end else begin
            sel_valid <= in_valid;
            if (in_valid) begin
                sel_ops <= ops_next;  // hold between items
            end
        end
    end

    // a bad stage would silently pick the wrong factors downstream
    a_stage_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid |-> !$isunknown(stage)
    );

endmodule

`default_nettype wire

// File: logic/twiddle_pkg.sv
`default_nettype none

`include "twiddle_macros.svh"

package twiddle_pkg;

    typedef logic [`TW_DATA_WIDTH-1:0] word_t;  // residue or modulus
    typedef logic [`TW_WIDE_WIDTH-1:0] wide_t;  // product before mod n

    typedef word_t [`TW_LANES-1:0] lane_vec_t;

    // which factors take part in the product
    typedef enum logic [1:0] {
        stage_full     = 2'd0,  // v0 * v1 * v2
        stage_pair     = 2'd1,  // v2 forced to one
        stage_single_a = 2'd2,  // v1, v2 forced to one
        stage_single_b = 2'd3
    } fft_stage_e;

    typedef struct packed {
        lane_vec_t v0;
        lane_vec_t v1;
        lane_vec_t v2;
    } operand_set_t;

    // same word in every lane
    function automatic lane_vec_t lane_fill(word_t w);
        lane_vec_t v;
        for (int i = 0; i < `TW_LANES; i++) begin
            v[i] = w;
        end
        return v;
    endfunction

endpackage

`default_nettype wire

// File: logic/twiddle_macros.svh
`ifndef TWIDDLE_MACROS_SVH
`define TWIDDLE_MACROS_SVH

// residue width, one ROM word per lane
`define TW_DATA_WIDTH 32

// lanes processed side by side
`define TW_LANES 4

// cycles through one mod_mul_array
// full product in the first cycle, reduction in the second
`define TW_MUL_LAT 2

// width of an unreduced product
`define TW_WIDE_WIDTH (2 * `TW_DATA_WIDTH)

`endif
